// File: periph_pkg.sv
/*
 * Shared bus types for the peripheral hub: transfer size enum, request and
 * response structs, pin function codes, slot numbers, register offsets and
 * the byte-lane merge used by sized register writes
 */
`default_nettype none

package periph_pkg;

    // Size encoding as driven by the core, SZ_NONE means no access
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10,
        SZ_NONE = 2'b11
    } xfer_size_e;

    typedef struct packed {
        logic [10:0] addr;
        logic [31:0] wdata;
        xfer_size_e  wsize;
        xfer_size_e  rsize;
    } bus_req_t;

    // Answer from a user-slot peripheral
    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
    } periph_rsp_t;

    // Output function per pin, other codes drive the pin low
    typedef enum logic [7:0] {
        FUNC_GPIO = 8'd0,
        FUNC_UART = 8'd2
    } pin_func_e;

    localparam logic [3:0] SLOT_GPIO  = 4'd1;
    localparam logic [3:0] SLOT_UART  = 4'd2;
    localparam logic [3:0] SLOT_TIMER = 4'd3;

    // Offsets inside a 64 byte user slot
    localparam logic [5:0] GPIO_OUT     = 6'h00;
    localparam logic [5:0] GPIO_IN      = 6'h04;
    localparam logic [5:0] GPIO_FUNC    = 6'h20;
    localparam logic [5:0] UART_DATA    = 6'h00;
    localparam logic [5:0] UART_STATUS  = 6'h04;
    localparam logic [5:0] UART_IRQ_CLR = 6'h08;
    localparam logic [5:0] TMR_CMP      = 6'h00;
    localparam logic [5:0] TMR_COUNT    = 6'h04;
    localparam logic [5:0] TMR_IRQ_CLR  = 6'h08;

    // Byte lanes follow the size: byte 7:0, half 15:0, word all
    function automatic logic [31:0] lane_merge(logic [31:0] cur, logic [31:0] wdata,
                                               xfer_size_e size);
        logic [31:0] res;
        res = cur;
        if (size != SZ_NONE) res[7:0] = wdata[7:0];
        if (size == SZ_HALF || size == SZ_WORD) res[15:8] = wdata[15:8];
        if (size == SZ_WORD) res[31:16] = wdata[31:16];
        return res;
    endfunction

endpackage

`default_nettype wire

// File: periph_scratch.sv
/*
 * Scratch peripheral for a simple slot: sixteen byte registers with
 * write strobe and combinational read
 */
`timescale 1ns/1ps
`default_nettype none

module periph_scratch (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       write,
    input  wire logic [3:0] offset,
    input  wire logic [7:0] wdata,
    output logic [7:0]      rdata
);

    logic [7:0] regs [16];

    // One byte per offset, strobe only comes when this slot is selected
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) regs[i] <= 8'h0;
        end else if (write) begin
            regs[offset] <= wdata;
        end
    end

    // Always ready, no wait state
    assign rdata = regs[offset];

endmodule

`default_nettype wire

// File: periph_timer.sv
/*
 * Compare timer: free-running 32-bit counter, compare register with
 * byte-lane writes and sticky match interrupt
 */
`timescale 1ns/1ps
`default_nettype none

module periph_timer (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire periph_pkg::bus_req_t  req,
    output periph_pkg::periph_rsp_t    rsp,
    output logic                       irq
);

    logic [31:0] count;
    logic [31:0] cmp;
    logic        wr;
    logic        match;

    assign wr    = (req.wsize != periph_pkg::SZ_NONE);
    assign match = (count == cmp);

    // Counter never stops
    always_ff @(posedge clk) begin
        if (!rst_n) count <= 32'h0;
        else count <= count + 32'd1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmp <= 32'h0;
        end else if (wr && req.addr[5:0] == periph_pkg::TMR_CMP) begin
            cmp <= periph_pkg::lane_merge(cmp, req.wdata, req.wsize);
        end
    end

    // Sticky, a match on the clear edge keeps it set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else if (match) begin
            irq <= 1'b1;
        end else if (wr && req.addr[5:0] == periph_pkg::TMR_IRQ_CLR) begin
            irq <= 1'b0;
        end
    end

    always_comb begin
        rsp.ready = (req.rsize != periph_pkg::SZ_NONE);
        case (req.addr[5:0])
            periph_pkg::TMR_CMP:   rsp.rdata = cmp;
            // Live value, not a snapshot
            periph_pkg::TMR_COUNT: rsp.rdata = count;
            default:               rsp.rdata = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

// File: periph_uart_tx.sv
/*
 * UART transmitter, 8N1 frame with CLKS_PER_BIT clocks per bit,
 * busy status and sticky done interrupt
 */
`timescale 1ns/1ps
`default_nettype none

module periph_uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire periph_pkg::bus_req_t  req,
    output periph_pkg::periph_rsp_t    rsp,
    output logic                       tx,
    output logic                       irq
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } tx_state_e;

    tx_state_e  state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift;
    logic       bit_end;
    logic       wr;
    logic       busy;

    assign wr      = (req.wsize != periph_pkg::SZ_NONE);
    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign busy    = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            clk_cnt <= '0;
            bit_idx <= 3'd0;
            shift   <= 8'h0;
            irq     <= 1'b0;
        end else begin
            // Clear first so a finishing frame wins on the same edge
            if (wr && req.addr[5:0] == periph_pkg::UART_IRQ_CLR) irq <= 1'b0;

            if (state == ST_IDLE) begin
                clk_cnt <= '0;
                // Writes while busy are dropped
                if (wr && req.addr[5:0] == periph_pkg::UART_DATA) begin
                    shift   <= req.wdata[7:0];
                    bit_idx <= 3'd0;
                    state   <= ST_START;
                end
            end else if (!bit_end) begin
                clk_cnt <= clk_cnt + 1'b1;
            end else begin
                clk_cnt <= '0;
                case (state)
                    ST_START: state <= ST_DATA;
                    ST_DATA: begin
                        // LSB first
                        shift   <= {1'b0, shift[7:1]};
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= ST_STOP;
                    end
                    default: begin
                        state <= ST_IDLE;
                        irq   <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Line level per state, idle and stop are mark
    always_comb begin
        case (state)
            ST_START: tx = 1'b0;
            ST_DATA:  tx = shift[0];
            default:  tx = 1'b1;
        endcase
    end

    always_comb begin
        rsp.ready = (req.rsize != periph_pkg::SZ_NONE);
        if (req.addr[5:0] == periph_pkg::UART_STATUS) rsp.rdata = {30'h0, irq, busy};
        else rsp.rdata = 32'h0;
    end

endmodule

`default_nettype wire

// File: periph_gpio.sv
/*
 * GPIO peripheral: output register, two-stage input synchronizer,
 * eight function select registers and per-pin output selection
 */
`timescale 1ns/1ps
`default_nettype none

module periph_gpio (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire periph_pkg::bus_req_t  req,
    output periph_pkg::periph_rsp_t    rsp,
    input  wire logic [7:0]            ui_in,
    input  wire logic                  uart_tx,
    output logic [7:0]                 uo_out,
    output logic [7:0]                 ui_sync
);

    logic [7:0]  gpio_out;
    logic [7:0]  ui_meta;
    logic [31:0] func_sel [8];
    logic        func_hit;
    logic [2:0]  func_idx;

    // Function select n sits at 0x20 + 4n
    assign func_hit = req.addr[5] && req.addr[1:0] == 2'b00;
    assign func_idx = req.addr[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= 8'h0;
            for (int i = 0; i < 8; i++) func_sel[i] <= 32'h0;
        end else if (req.wsize != periph_pkg::SZ_NONE) begin
            // Output register takes the low byte for any size
            if (req.addr[5:0] == periph_pkg::GPIO_OUT) gpio_out <= req.wdata[7:0];
            if (func_hit) begin
                func_sel[func_idx] <= periph_pkg::lane_merge(func_sel[func_idx],
                                                             req.wdata, req.wsize);
            end
        end
    end

    // Two flops on the pad inputs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ui_meta <= 8'h0;
            ui_sync <= 8'h0;
        end else begin
            ui_meta <= ui_in;
            ui_sync <= ui_meta;
        end
    end

    always_comb begin
        rsp.ready = (req.rsize != periph_pkg::SZ_NONE);
        if (req.addr[5:0] == periph_pkg::GPIO_OUT) rsp.rdata = {24'h0, gpio_out};
        else if (req.addr[5:0] == periph_pkg::GPIO_IN) rsp.rdata = {24'h0, ui_sync};
        else if (func_hit) rsp.rdata = func_sel[func_idx];
        else rsp.rdata = 32'h0;
    end

    // Pin mux, low byte of each select is the function code
    always_comb begin
        for (int n = 0; n < 8; n++) begin
            case (periph_pkg::pin_func_e'(func_sel[n][7:0]))
                periph_pkg::FUNC_GPIO: uo_out[n] = gpio_out[n];
                periph_pkg::FUNC_UART: uo_out[n] = uart_tx;
                default:               uo_out[n] = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: periph_hub.sv
/*
 * Peripheral hub top level: slot decode, per-peripheral request gating,
 * response select, read data hold register and registered ready,
 * GPIO, UART transmitter, timer and scratch register instances
 */
`timescale 1ns/1ps
`default_nettype none

module periph_hub #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic [7:0]           ui_in,
    output logic [7:0]                uo_out,
    input  wire periph_pkg::bus_req_t req,
    output logic [31:0]               data_out,
    output logic                      data_ready,
    input  wire logic                 data_read_complete,
    output logic [15:2]               user_interrupts
);

    // Scratch registers live in simple slot 0
    localparam logic [3:0] SIMPLE_SCRATCH = 4'd0;

    logic       sel_simple;
    logic [3:0] user_slot;
    logic [3:0] simple_slot;
    logic       rd_valid;

    periph_pkg::bus_req_t    gpio_req;
    periph_pkg::bus_req_t    uart_req;
    periph_pkg::bus_req_t    tmr_req;
    periph_pkg::periph_rsp_t gpio_rsp;
    periph_pkg::periph_rsp_t uart_rsp;
    periph_pkg::periph_rsp_t tmr_rsp;
    periph_pkg::periph_rsp_t user_rsp;

    logic        scratch_wr;
    logic [7:0]  scratch_rdata;
    logic [31:0] sel_rdata;
    logic        sel_ready;
    logic        hold;
    logic        uart_tx;
    logic        uart_irq;
    logic        tmr_irq;

    // Unselected peripherals see no access at all
    function automatic periph_pkg::bus_req_t gate_req(periph_pkg::bus_req_t r, logic sel);
        periph_pkg::bus_req_t g;
        g = r;
        if (!sel) begin
            g.wsize = periph_pkg::SZ_NONE;
            g.rsize = periph_pkg::SZ_NONE;
        end
        return g;
    endfunction

    // Bit 10 picks simple slots, otherwise user slot from bits 9:6
    assign sel_simple  = req.addr[10];
    assign user_slot   = req.addr[9:6];
    assign simple_slot = req.addr[7:4];
    assign rd_valid    = (req.rsize != periph_pkg::SZ_NONE);

    assign gpio_req = gate_req(req, !sel_simple && user_slot == periph_pkg::SLOT_GPIO);
    assign uart_req = gate_req(req, !sel_simple && user_slot == periph_pkg::SLOT_UART);
    assign tmr_req  = gate_req(req, !sel_simple && user_slot == periph_pkg::SLOT_TIMER);

    assign scratch_wr = sel_simple && simple_slot == SIMPLE_SCRATCH &&
                        req.wsize != periph_pkg::SZ_NONE;

    // User slot response, empty slots give zero at once
    always_comb begin
        user_rsp.rdata = 32'h0;
        user_rsp.ready = rd_valid;
        case (user_slot)
            periph_pkg::SLOT_GPIO:  user_rsp = gpio_rsp;
            periph_pkg::SLOT_UART:  user_rsp = uart_rsp;
            periph_pkg::SLOT_TIMER: user_rsp = tmr_rsp;
            default: ;
        endcase
    end

    // Simple slots are always ready, only slot 0 is populated
    always_comb begin
        if (sel_simple) begin
            sel_rdata = (simple_slot == SIMPLE_SCRATCH) ? {24'h0, scratch_rdata} : 32'h0;
            sel_ready = rd_valid;
        end else begin
            sel_rdata = user_rsp.rdata;
            sel_ready = user_rsp.ready;
        end
    end

    // Capture once per read, keep until the core completes it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold       <= 1'b0;
            data_out   <= 32'h0;
            data_ready <= 1'b0;
        end else begin
            if (data_read_complete) hold <= 1'b0;
            if (!hold && sel_ready) begin
                hold     <= 1'b1;
                data_out <= sel_rdata;
            end
            // Ready lines up with the registered data
            data_ready <= sel_ready;
        end
    end

    periph_gpio gpio0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (gpio_req),
        .rsp     (gpio_rsp),
        .ui_in   (ui_in),
        .uart_tx (uart_tx),
        .uo_out  (uo_out),
        .ui_sync ()
    );

    periph_uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (uart_req),
        .rsp   (uart_rsp),
        .tx    (uart_tx),
        .irq   (uart_irq)
    );

    periph_timer timer0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (tmr_req),
        .rsp   (tmr_rsp),
        .irq   (tmr_irq)
    );

    periph_scratch scratch0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .write  (scratch_wr),
        .offset (req.addr[3:0]),
        .wdata  (req.wdata[7:0]),
        .rdata  (scratch_rdata)
    );

    // Interrupt bit follows the user slot number
    assign user_interrupts = {12'h0, tmr_irq, uart_irq};

endmodule

`default_nettype wire

// File: periph_hub_sva.sv
/*
 * Assertions bound into the hub: read data hold, ready low after reset,
 * ready one cycle after a read to a populated slot
 */
`timescale 1ns/1ps
`default_nettype none

module periph_hub_sva (
    input wire logic                 clk,
    input wire logic                 rst_n,
    input wire periph_pkg::bus_req_t req,
    input wire logic [31:0]          data_out,
    input wire logic                 data_ready,
    input wire logic                 data_read_complete,
    input wire logic                 hold
);

    logic rd_valid;
    logic populated;

    assign rd_valid = (req.rsize != periph_pkg::SZ_NONE);

    // Simple slot 0 and user slots 1 to 3 carry peripherals
    assign populated = req.addr[10] ? (req.addr[7:4] == 4'd0)
                                    : (req.addr[9:6] == periph_pkg::SLOT_GPIO ||
                                       req.addr[9:6] == periph_pkg::SLOT_UART ||
                                       req.addr[9:6] == periph_pkg::SLOT_TIMER);

    // Captured data stays put until the core completes the read
    hold_keeps_data: assert property (@(posedge clk) disable iff (!rst_n)
        hold && !data_read_complete |=> $stable(data_out))
        else $error("data_out changed while a read was held");

    ready_low_after_reset: assert property (@(posedge clk) !rst_n |=> !data_ready)
        else $error("data_ready high in the cycle after reset");

    // Combinational peripherals, so ready follows one register later
    ready_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid && populated |=> data_ready)
        else $error("data_ready missing one cycle after a read request");

endmodule

bind periph_hub periph_hub_sva sva0 (
    .clk                (clk),
    .rst_n              (rst_n),
    .req                (req),
    .data_out           (data_out),
    .data_ready         (data_ready),
    .data_read_complete (data_read_complete),
    .hold               (hold)
);

`default_nettype wire

// File: tb_periph_hub.sv
/*
 * Testbench for the peripheral hub: clock, reset, bus tasks, stimulus table
 * for GPIO, sized writes and scratch slots, UART frame, timer compare and
 * read hold sequences, compare tasks and result counts
 */
`timescale 1ns/1ps
`default_nettype none

module tb_periph_hub;

    localparam int CLKS_PER_BIT = 8;
    localparam int WAIT_LIMIT   = 400;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_PINS, OP_UI} op_e;

    // One table row, exp is the read value or the pin value
    typedef struct packed {
        logic [2:0]             test_no;
        op_e                    op;
        logic [10:0]            addr;
        periph_pkg::xfer_size_e size;
        logic [31:0]            wdata;
        logic [31:0]            exp;
    } step_t;

    logic                 clk;
    logic                 rst_n;
    logic [7:0]           ui_in;
    logic [7:0]           uo_out;
    periph_pkg::bus_req_t req;
    logic [31:0]          data_out;
    logic                 data_ready;
    logic                 data_read_complete;
    logic [15:2]          user_interrupts;

    step_t       steps[$];
    logic [31:0] func_model [8];
    logic [7:0]  out_model;
    int          err_count;
    int          err_mark;
    int          test_count;

    periph_hub #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut0 (
        .clk                (clk),
        .rst_n              (rst_n),
        .ui_in              (ui_in),
        .uo_out             (uo_out),
        .req                (req),
        .data_out           (data_out),
        .data_ready         (data_ready),
        .data_read_complete (data_read_complete),
        .user_interrupts    (user_interrupts)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // User slot n at 64*n, simple slot n at 0x400 + 16*n
    function automatic logic [10:0] user_addr(logic [3:0] slot, logic [5:0] off);
        return {1'b0, slot, off};
    endfunction

    function automatic logic [10:0] simple_addr(logic [3:0] slot, logic [3:0] off);
        return {3'b100, slot, off};
    endfunction

    // Bytes a write of this size touches
    function automatic logic [31:0] size_mask(periph_pkg::xfer_size_e size);
        case (size)
            periph_pkg::SZ_BYTE: return 32'h0000_00ff;
            periph_pkg::SZ_HALF: return 32'h0000_ffff;
            periph_pkg::SZ_WORD: return 32'hffff_ffff;
            default:             return 32'h0;
        endcase
    endfunction

    // Expected pins from the function codes, UART line idles high
    function automatic logic [7:0] pins_model();
        logic [7:0] p;
        for (int n = 0; n < 8; n++) begin
            if (func_model[n][7:0] == 8'd0) p[n] = out_model[n];
            else if (func_model[n][7:0] == 8'd2) p[n] = 1'b1;
            else p[n] = 1'b0;
        end
        return p;
    endfunction

    function automatic string test_name(logic [2:0] t);
        case (t)
            3'd0:    return "gpio";
            3'd1:    return "sized writes";
            default: return "scratch and empty slots";
        endcase
    endfunction

    task automatic check_data(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_pins(logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            $display("Mismatch uo_out: got 0x%02h, expected 0x%02h", got, exp);
            err_count++;
        end
    endtask

    task automatic check_irq(logic [15:2] got, logic [15:2] exp);
        if (got !== exp) begin
            $display("Mismatch user_interrupts: got 0x%04h, expected 0x%04h", got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(string name);
        test_count++;
        if (err_count == err_mark) $display("Test %s: pass", name);
        else $display("Test %s: fail with %0d error(s)", name, err_count - err_mark);
        err_mark = err_count;
    endtask

    // Single-cycle write strobe
    task automatic bus_write(logic [10:0] addr, periph_pkg::xfer_size_e size,
                             logic [31:0] wdata);
        @(posedge clk);
        req.addr  <= addr;
        req.wdata <= wdata;
        req.wsize <= size;
        @(posedge clk);
        req.wsize <= periph_pkg::SZ_NONE;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!data_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!data_ready) begin
            $display("Read at address 0x%03h never got data_ready", req.addr);
            err_count++;
        end
    endtask

    // Drop the request and pulse the completion for one cycle
    task automatic read_complete();
        @(posedge clk);
        req.rsize          <= periph_pkg::SZ_NONE;
        data_read_complete <= 1'b1;
        @(posedge clk);
        data_read_complete <= 1'b0;
    endtask

    task automatic bus_read(logic [10:0] addr, periph_pkg::xfer_size_e size,
                            output logic [31:0] data);
        @(posedge clk);
        req.addr  <= addr;
        req.rsize <= size;
        wait_ready();
        data = data_out;
        read_complete();
    endtask

    task automatic wait_irq(int bit_no, string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!user_interrupts[bit_no] && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!user_interrupts[bit_no]) begin
            $display("The %s interrupt never went high", what);
            err_count++;
        end
    endtask

    function automatic void add_step(logic [2:0] t, op_e op, logic [10:0] a,
                                     periph_pkg::xfer_size_e sz, logic [31:0] wd,
                                     logic [31:0] ex);
        steps.push_back(step_t'{t, op, a, sz, wd, ex});
    endfunction

    // Merge into the model, then queue the write and a word read back
    task automatic add_func_write(int pin, periph_pkg::xfer_size_e sz, logic [31:0] wd);
        logic [31:0] m;
        logic [10:0] a;
        m = size_mask(sz);
        a = user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_FUNC + 6'(pin * 4));
        func_model[pin] = (func_model[pin] & ~m) | (wd & m);
        add_step(3'd1, OP_WR, a, sz, wd, 32'h0);
        add_step(3'd1, OP_RD, a, periph_pkg::SZ_WORD, 32'h0, func_model[pin]);
    endtask

    task automatic build_table();
        logic [31:0] wd [4];
        logic [10:0] a_out;
        a_out = user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT);
        // GPIO output register, pins, then the synchronized input
        out_model = 8'ha5;
        add_step(3'd0, OP_WR, a_out, periph_pkg::SZ_BYTE, 32'h0000_00a5, 32'h0);
        add_step(3'd0, OP_RD, a_out, periph_pkg::SZ_WORD, 32'h0, 32'h0000_00a5);
        add_step(3'd0, OP_PINS, 11'h0, periph_pkg::SZ_NONE, 32'h0, {24'h0, pins_model()});
        add_step(3'd0, OP_UI, 11'h0, periph_pkg::SZ_NONE, 32'h0000_003c, 32'h0);
        add_step(3'd0, OP_RD, user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_IN),
                 periph_pkg::SZ_WORD, 32'h0, 32'h0000_003c);
        // Sized writes, pins 1 and 3 end on unused codes
        out_model = 8'hff;
        add_step(3'd1, OP_WR, a_out, periph_pkg::SZ_BYTE, 32'h0000_00ff, 32'h0);
        add_func_write(1, periph_pkg::SZ_WORD, 32'h1234_5678);
        add_func_write(1, periph_pkg::SZ_BYTE, 32'h5555_55ab);
        add_func_write(1, periph_pkg::SZ_HALF, 32'hffff_cd05);
        add_func_write(3, periph_pkg::SZ_HALF, 32'h8000_0107);
        add_func_write(6, periph_pkg::SZ_WORD, 32'hdead_be00);
        add_step(3'd1, OP_PINS, 11'h0, periph_pkg::SZ_NONE, 32'h0, {24'h0, pins_model()});
        // Scratch bytes, upper write bits must be dropped
        for (int i = 0; i < 4; i++) begin
            wd[i] = $urandom();
            // Nonzero bytes so an aliased simple slot reads back something
            if (wd[i][7:0] == 8'h00) wd[i][7:0] = 8'h5a;
            add_step(3'd4, OP_WR, simple_addr(4'd0, 4'(i * 5)), periph_pkg::SZ_BYTE,
                     wd[i], 32'h0);
        end
        for (int i = 0; i < 4; i++) begin
            add_step(3'd4, OP_RD, simple_addr(4'd0, 4'(i * 5)), periph_pkg::SZ_BYTE,
                     32'h0, {24'h0, wd[i][7:0]});
        end
        // Slot 5 at an offset that holds a scratch byte in slot 0
        add_step(3'd4, OP_RD, simple_addr(4'd5, 4'd5), periph_pkg::SZ_BYTE, 32'h0, 32'h0);
        add_step(3'd4, OP_RD, user_addr(4'd9, 6'h04), periph_pkg::SZ_WORD, 32'h0, 32'h0);
    endtask

    task automatic uart_test();
        logic [31:0] r;
        logic [31:0] rd;
        logic [9:0]  frame;
        int          n;
        r = $urandom();
        func_model[0] = {24'h0, periph_pkg::FUNC_UART};
        bus_write(user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_FUNC),
                  periph_pkg::SZ_BYTE, func_model[0]);
        bus_write(user_addr(periph_pkg::SLOT_UART, periph_pkg::UART_DATA),
                  periph_pkg::SZ_BYTE, r);
        n = 0;
        @(negedge clk);
        while (uo_out[0] && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (uo_out[0]) begin
            $display("No start bit seen on pin 0");
            err_count++;
        end
        // Middle of the start bit, then one sample per bit period
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
        for (int b = 0; b < 10; b++) begin
            frame[b] = uo_out[0];
            if (b < 9) repeat (CLKS_PER_BIT) @(negedge clk);
        end
        check_data("uart frame", {22'h0, frame}, {22'h0, 1'b1, r[7:0], 1'b0});
        wait_irq(2, "UART");
        // Timer irq is still set, compare zero matched right after reset
        check_irq(user_interrupts, 14'h0003);
        bus_read(user_addr(periph_pkg::SLOT_UART, periph_pkg::UART_STATUS),
                 periph_pkg::SZ_WORD, rd);
        check_data("uart status", rd, 32'h0000_0002);
        bus_write(user_addr(periph_pkg::SLOT_UART, periph_pkg::UART_IRQ_CLR),
                  periph_pkg::SZ_WORD, 32'h0);
        bus_read(user_addr(periph_pkg::SLOT_UART, periph_pkg::UART_STATUS),
                 periph_pkg::SZ_WORD, rd);
        check_data("uart status", rd, 32'h0);
        @(negedge clk);
        check_irq(user_interrupts, 14'h0002);
    endtask

    task automatic timer_test();
        logic [31:0] cnt;
        bus_read(user_addr(periph_pkg::SLOT_TIMER, periph_pkg::TMR_COUNT),
                 periph_pkg::SZ_WORD, cnt);
        bus_write(user_addr(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CMP),
                  periph_pkg::SZ_WORD, cnt + 32'd50);
        bus_write(user_addr(periph_pkg::SLOT_TIMER, periph_pkg::TMR_IRQ_CLR),
                  periph_pkg::SZ_WORD, 32'h0);
        @(negedge clk);
        check_irq(user_interrupts, 14'h0000);
        wait_irq(3, "timer");
        check_irq(user_interrupts, 14'h0002);
        bus_write(user_addr(periph_pkg::SLOT_TIMER, periph_pkg::TMR_IRQ_CLR),
                  periph_pkg::SZ_WORD, 32'h0);
        @(negedge clk);
        check_irq(user_interrupts, 14'h0000);
    endtask

    task automatic hold_test();
        logic [31:0] rd;
        logic [10:0] a_out;
        a_out = user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT);
        bus_write(a_out, periph_pkg::SZ_BYTE, 32'h0000_0011);
        @(posedge clk);
        req.addr  <= a_out;
        req.rsize <= periph_pkg::SZ_WORD;
        wait_ready();
        check_data("data_out", data_out, 32'h0000_0011);
        // Overwrite while the read is still open
        out_model = 8'h22;
        @(posedge clk);
        req.wdata <= 32'h0000_0022;
        req.wsize <= periph_pkg::SZ_BYTE;
        @(posedge clk);
        req.wsize <= periph_pkg::SZ_NONE;
        repeat (4) begin
            @(negedge clk);
            check_data("data_out", data_out, 32'h0000_0011);
        end
        check_pins(uo_out, pins_model());
        read_complete();
        bus_read(a_out, periph_pkg::SZ_WORD, rd);
        check_data("data_out", rd, 32'h0000_0022);
    endtask

    initial begin
        step_t       s;
        logic [31:0] rd;
        void'($urandom(20548));
        err_count  = 0;
        err_mark   = 0;
        test_count = 0;
        rst_n              <= 1'b0;
        ui_in              <= 8'h0;
        req                <= '{addr: '0, wdata: '0, wsize: periph_pkg::SZ_NONE,
                                rsize: periph_pkg::SZ_NONE};
        data_read_complete <= 1'b0;
        for (int n = 0; n < 8; n++) func_model[n] = 32'h0;
        build_table();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            s = steps[i];
            case (s.op)
                OP_WR: bus_write(s.addr, s.size, s.wdata);
                OP_RD: begin
                    bus_read(s.addr, s.size, rd);
                    check_data("data_out", rd, s.exp);
                end
                OP_PINS: begin
                    @(negedge clk);
                    check_pins(uo_out, s.exp[7:0]);
                end
                default: begin
                    // Two sync stages plus one spare cycle
                    @(posedge clk);
                    ui_in <= s.wdata[7:0];
                    repeat (3) @(posedge clk);
                end
            endcase
            if (i == steps.size() - 1 || steps[i + 1].test_no != s.test_no)
                report_test(test_name(s.test_no));
        end
        uart_test();
        report_test("uart");
        timer_test();
        report_test("timer");
        hold_test();
        report_test("read hold");
        $display("Tests run %0d, errors %0d", test_count, err_count);
        if (err_count == 0) $display("No errors");
        else $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
periph_pkg.sv
periph_scratch.sv
periph_timer.sv
periph_uart_tx.sv
periph_gpio.sv
periph_hub.sv
periph_hub_sva.sv
tb_periph_hub.sv

// File: run.sh
#!/bin/bash
# Build the testbench with Verilator, run it, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_periph_hub \
    -o tb_periph_hub > build.log 2>&1 \
    && ./obj_dir/tb_periph_hub > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^No errors$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
